// ==== source/bs_pkg.sv ====
//**********************************************************
// Shared constants and request types of the bank scheduler
// Imported by every RTL block of the subsystem
//**********************************************************
package bs_pkg;

  //**********************************************************
  // FIFO organisation
  //**********************************************************
  localparam int RD_FIFO_NUM = 4;                          // Read request FIFOs
  localparam int WR_FIFO_NUM = 3;                          // Write request FIFOs
  localparam int FIFO_NUM    = RD_FIFO_NUM + WR_FIFO_NUM;  // Reads low, writes high
  localparam int FIFO_DEPTH  = 4;                          // Entries per FIFO
  localparam int CNT_W       = 3;                          // Occupancy 0..FIFO_DEPTH
  localparam int IDX_W       = 3;                          // Index of one FIFO
  localparam int RD_PTR_W    = $clog2(RD_FIFO_NUM);        // Read round-robin pointer
  localparam int WR_PTR_W    = $clog2(WR_FIFO_NUM);        // Write round-robin pointer
  localparam int WR_SUM_W    = $clog2(WR_FIFO_NUM * FIFO_DEPTH + 1);

  // Direction masks over the one-hot FIFO vector
  localparam logic [FIFO_NUM-1:0] RD_MASK = 7'b000_1111;
  localparam logic [FIFO_NUM-1:0] WR_MASK = 7'b111_0000;

  // Request fields
  localparam int BURST_W = 16;  // Row address
  localparam int COL_W   = 8;
  localparam int DATA_W  = 32;
  localparam int TAG_W   = 4;   // Read tag, returned with the data

  // Write mode hysteresis, in pending writes
  localparam int WR_HI_MARK = 6;
  localparam int WR_LO_MARK = 2;

  //**********************************************************
  // Types
  //**********************************************************
  typedef enum logic {MODE_WRITE = 1'b0, MODE_READ = 1'b1} bus_mode_e;

  typedef struct packed {
    logic [BURST_W-1:0] burst;
    logic [COL_W-1:0]   col;
    logic [TAG_W-1:0]   tag;
  } rd_req_t;  // 28 bits

  typedef struct packed {
    logic [BURST_W-1:0] burst;
    logic [COL_W-1:0]   col;
    logic [DATA_W-1:0]  data;
  } wr_req_t;  // 56 bits

  typedef struct packed {
    logic               wr;     // Set for a write request
    logic [IDX_W-1:0]   idx;    // Source FIFO
    logic [BURST_W-1:0] burst;
    logic [COL_W-1:0]   col;
    logic [DATA_W-1:0]  data;   // Zero on reads
    logic [TAG_W-1:0]   tag;    // Zero on writes
  } issue_t;  // 64 bits

endpackage

// ==== source/bs_req_fifo.sv ====
//**********************************************************
// Request FIFO with its head visible combinationally
// Payload type set per instance, a push to a full FIFO is lost
//**********************************************************
`timescale 1ns/1ns

module bs_req_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = bs_pkg::FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push_i,   // Store data_i
  input  payload_t                 data_i,
  input  logic                     pop_i,    // Drop the head
  output payload_t                 head_o,   // Oldest entry
  output logic                     empty_o,
  output logic                     full_o,
  output logic [bs_pkg::CNT_W-1:0] count_o   // Entries held
);
  import bs_pkg::*;

  payload_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;     // Next free slot
  logic [$clog2(DEPTH)-1:0]   rd_ptr;     // Head slot
  logic [CNT_W-1:0]           count_q;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push_i & ~full_o;   // Overflow is dropped
  assign do_pop  = pop_i & ~empty_o;   // Guard, scheduler never pops empty

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;  // Wrap
      end
      if (do_pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;       // Both or neither
      endcase
    end
  end

  assign head_o  = mem[rd_ptr];
  assign empty_o = (count_q == '0);
  assign full_o  = (int'(count_q) == DEPTH);
  assign count_o = count_q;

endmodule

// ==== source/bs_mode_ctrl.sv ====
//**********************************************************
// Bus direction control by write watermarks
// Read first, write mode between high and low watermark
//**********************************************************
`timescale 1ns/1ns

module bs_mode_ctrl (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [bs_pkg::WR_FIFO_NUM-1:0][bs_pkg::CNT_W-1:0] wr_count_i,
  input  logic [bs_pkg::RD_FIFO_NUM-1:0]                    rd_empty_i,
  input  logic [bs_pkg::WR_FIFO_NUM-1:0]                    wr_empty_i,
  output bs_pkg::bus_mode_e                                 mode_o
);
  import bs_pkg::*;

  logic [WR_SUM_W-1:0] wr_sum;    // Pending writes over all write FIFOs
  logic                rd_none;   // No read waiting
  logic                wr_none;
  bus_mode_e           mode_d;
  bus_mode_e           mode_q;

  always_comb begin
    wr_sum = '0;
    for (int i = 0; i < WR_FIFO_NUM; i++) begin
      wr_sum = wr_sum + WR_SUM_W'(wr_count_i[i]);
    end
  end

  assign rd_none = &rd_empty_i;
  assign wr_none = &wr_empty_i;

  // Hysteresis
  always_comb begin
    mode_d = mode_q;
    if (mode_q == MODE_READ) begin
      if ((int'(wr_sum) >= WR_HI_MARK) || (rd_none && !wr_none)) begin
        mode_d = MODE_WRITE;   // High watermark, or idle reads let writes drain
      end
    end else if (wr_none || ((int'(wr_sum) <= WR_LO_MARK) && !rd_none)) begin
      mode_d = MODE_READ;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) mode_q <= MODE_READ;   // Read first out of reset
    else        mode_q <= mode_d;
  end

  assign mode_o = mode_q;

endmodule

// ==== source/bs_burst_sched.sv ====
//**********************************************************
// Burst-grouping round-robin scheduler for one bank
// Leads a burst from the RR pointer, then drains matching heads
//**********************************************************
`timescale 1ns/1ns

module bs_burst_sched (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             ready_i,   // Arbiter ready level
  input  bs_pkg::bus_mode_e                                mode_i,    // Bus direction
  input  logic [bs_pkg::FIFO_NUM-1:0][bs_pkg::BURST_W-1:0] burst_i,   // Head burst addresses
  input  logic [bs_pkg::FIFO_NUM-1:0]                      empty_i,
  output logic [bs_pkg::FIFO_NUM-1:0]                      pop_o,     // One-hot pop
  output logic                                             valid_o    // Issue valid
);
  import bs_pkg::*;

  //**********************************************************
  // Declarations
  //**********************************************************
  typedef enum logic [2:0] {
    IDLE,       // Nothing queued in the current mode
    WAITING,    // Request offered, waits for ready
    RD_BURST,   // Draining reads of the latched burst
    WR_BURST,   // Draining writes of the latched burst
    FINISH      // One idle cycle after a burst
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic [BURST_W-1:0]    burst_q;    // Burst being drained
  logic [BURST_W-1:0]    burst_d;
  logic [RD_PTR_W-1:0]   rd_ptr_q;   // Next read FIFO to lead a burst
  logic [RD_PTR_W-1:0]   rd_ptr_d;
  logic [WR_PTR_W-1:0]   wr_ptr_q;   // Offset inside the write FIFOs
  logic [WR_PTR_W-1:0]   wr_ptr_d;
  logic [FIFO_NUM-1:0]   hits;       // Non-empty heads on the latched burst
  logic [FIFO_NUM-1:0]   rd_hits;
  logic [FIFO_NUM-1:0]   wr_hits;
  logic                  mode_busy;  // Current direction has work
  logic [IDX_W-1:0]      lead_idx;   // FIFO that opens the next burst

  // Index of the lowest set bit or zero for an empty vector
  function automatic logic [IDX_W-1:0] low_idx(input logic [FIFO_NUM-1:0] vec);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = FIFO_NUM - 1; i >= 0; i--) begin
      if (vec[i]) idx = IDX_W'(i);
    end
    return idx;
  endfunction

  //**********************************************************
  // Burst hits and leader selection
  //**********************************************************
  always_comb begin
    for (int i = 0; i < FIFO_NUM; i++) begin
      hits[i] = !empty_i[i] && (burst_i[i] == burst_q);
    end
  end

  assign rd_hits = hits & RD_MASK;
  assign wr_hits = hits & WR_MASK;

  assign mode_busy = (mode_i == MODE_READ) ? ~&empty_i[RD_FIFO_NUM-1:0]
                                           : ~&empty_i[FIFO_NUM-1:RD_FIFO_NUM];

  // Pointer FIFO if it holds work and otherwise the first busy one
  always_comb begin
    if (mode_i == MODE_READ) begin
      if (!empty_i[rd_ptr_q]) lead_idx = IDX_W'(rd_ptr_q);
      else                    lead_idx = low_idx(~empty_i & RD_MASK);
    end else begin
      if (!empty_i[RD_FIFO_NUM + int'(wr_ptr_q)]) begin
        lead_idx = IDX_W'(RD_FIFO_NUM + int'(wr_ptr_q));
      end else begin
        lead_idx = low_idx(~empty_i & WR_MASK);
      end
    end
  end

  //**********************************************************
  // Next state and outputs
  //**********************************************************
  always_comb begin
    state_d  = state_q;
    burst_d  = burst_q;
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    pop_o    = '0;
    valid_o  = 1'b0;
    case (state_q)
      IDLE: begin
        if (mode_busy) state_d = WAITING;
      end
      WAITING: begin
        if (!mode_busy) begin
          state_d = IDLE;              // Work vanished under a mode change
        end else begin
          valid_o = 1'b1;              // Held through back-pressure
          if (ready_i) begin
            pop_o[lead_idx] = 1'b1;
            burst_d         = burst_i[lead_idx];
            if (mode_i == MODE_READ) begin
              state_d  = RD_BURST;
              rd_ptr_d = (int'(rd_ptr_q) == RD_FIFO_NUM - 1) ? '0 : rd_ptr_q + 1'b1;
            end else begin
              state_d  = WR_BURST;
              wr_ptr_d = (int'(wr_ptr_q) == WR_FIFO_NUM - 1) ? '0 : wr_ptr_q + 1'b1;
            end
          end
        end
      end
      RD_BURST: begin
        if (|rd_hits) begin
          pop_o[low_idx(rd_hits)] = 1'b1;   // No wait for ready inside a burst
          valid_o                 = 1'b1;
        end else begin
          state_d = FINISH;
        end
      end
      WR_BURST: begin
        if (|wr_hits) begin
          pop_o[low_idx(wr_hits)] = 1'b1;
          valid_o                 = 1'b1;
        end else begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        state_d = mode_busy ? WAITING : IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  //**********************************************************
  // Registers
  //**********************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      state_q  <= state_d;
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
    end
  end

  // Burst address of the leading pop
  always_ff @(posedge clk) begin
    burst_q <= burst_d;
  end

endmodule

// ==== source/bank_sched_top.sv ====
//**********************************************************
// Bank scheduling top: seven request FIFOs, mode and scheduler
// Issue port carries the popped head in the cycle of its pop
//**********************************************************
`timescale 1ns/1ns

module bank_sched_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [bs_pkg::RD_FIFO_NUM-1:0] rd_push_i,     // One-hot read push
  input  bs_pkg::rd_req_t                rd_req_i,
  input  logic [bs_pkg::WR_FIFO_NUM-1:0] wr_push_i,     // One-hot write push
  input  bs_pkg::wr_req_t                wr_req_i,
  input  logic                           ready_i,       // Arbiter ready level
  output logic [bs_pkg::RD_FIFO_NUM-1:0] rd_full_o,
  output logic [bs_pkg::WR_FIFO_NUM-1:0] wr_full_o,
  output logic                           issue_valid_o,
  output bs_pkg::issue_t                 issue_o,
  output bs_pkg::bus_mode_e              mode_o
);
  import bs_pkg::*;

  rd_req_t                           rd_head [RD_FIFO_NUM];
  wr_req_t                           wr_head [WR_FIFO_NUM];
  logic [FIFO_NUM-1:0]               empty;      // Bit i is FIFO i
  logic [FIFO_NUM-1:0]               pop;
  logic [FIFO_NUM-1:0][BURST_W-1:0]  burst;      // Head bursts for hit search
  logic [WR_FIFO_NUM-1:0][CNT_W-1:0] wr_count;

  //**********************************************************
  // Request FIFOs
  //**********************************************************
  for (genvar g = 0; g < RD_FIFO_NUM; g++) begin : g_rd
    bs_req_fifo #(.payload_t(rd_req_t), .DEPTH(FIFO_DEPTH)) u_rd_fifo (
      .clk(clk), .rst_n(rst_n),
      .push_i(rd_push_i[g]), .data_i(rd_req_i), .pop_i(pop[g]),
      .head_o(rd_head[g]), .empty_o(empty[g]), .full_o(rd_full_o[g]),
      .count_o()  // Read occupancy not needed by the mode logic
    );
    assign burst[g] = rd_head[g].burst;
  end

  for (genvar g = 0; g < WR_FIFO_NUM; g++) begin : g_wr
    bs_req_fifo #(.payload_t(wr_req_t), .DEPTH(FIFO_DEPTH)) u_wr_fifo (
      .clk(clk), .rst_n(rst_n),
      .push_i(wr_push_i[g]), .data_i(wr_req_i), .pop_i(pop[RD_FIFO_NUM+g]),
      .head_o(wr_head[g]), .empty_o(empty[RD_FIFO_NUM+g]), .full_o(wr_full_o[g]),
      .count_o(wr_count[g])
    );
    assign burst[RD_FIFO_NUM+g] = wr_head[g].burst;
  end

  bs_mode_ctrl u_mode (
    .clk(clk), .rst_n(rst_n), .wr_count_i(wr_count),
    .rd_empty_i(empty[RD_FIFO_NUM-1:0]), .wr_empty_i(empty[FIFO_NUM-1:RD_FIFO_NUM]),
    .mode_o(mode_o)
  );

  bs_burst_sched u_sched (
    .clk(clk), .rst_n(rst_n), .ready_i(ready_i), .mode_i(mode_o),
    .burst_i(burst), .empty_i(empty), .pop_o(pop), .valid_o(issue_valid_o)
  );

  // Issue word from the popped head, zero without a pop
  always_comb begin
    issue_o = '0;
    for (int i = 0; i < RD_FIFO_NUM; i++) begin
      if (pop[i]) begin
        issue_o.idx   = IDX_W'(i);
        issue_o.burst = rd_head[i].burst;
        issue_o.col   = rd_head[i].col;
        issue_o.tag   = rd_head[i].tag;
      end
    end
    for (int i = 0; i < WR_FIFO_NUM; i++) begin
      if (pop[RD_FIFO_NUM+i]) begin
        issue_o.wr    = 1'b1;
        issue_o.idx   = IDX_W'(RD_FIFO_NUM + i);
        issue_o.burst = wr_head[i].burst;
        issue_o.col   = wr_head[i].col;
        issue_o.data  = wr_head[i].data;
      end
    end
  end

endmodule

// ==== verif/bank_sched_assert.sv ====
//**********************************************************
// Concurrent checks on the pop and valid of the burst scheduler
// Bound into every bs_burst_sched instance
//**********************************************************
`timescale 1ns/1ns

module bank_sched_assert (
  input logic                        clk,
  input logic                        rst_n,
  input logic [bs_pkg::FIFO_NUM-1:0] pop_o,
  input logic [bs_pkg::FIFO_NUM-1:0] empty_i,
  input logic                        valid_o
);
  int unsigned fail_cnt = 0;   // Failures seen, collected by the testbench

  a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop_o))
    else begin
      fail_cnt++;
      $error("More than one FIFO popped in a cycle");
    end

  a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) (pop_o & empty_i) == '0)
    else begin
      fail_cnt++;
      $error("Pop applied to an empty FIFO");
    end

  a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n) !valid_o |-> pop_o == '0)
    else begin
      fail_cnt++;
      $error("Pop while valid is low");
    end

  // Reset state is IDLE, nothing offered
  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (pop_o == '0 && !valid_o))
    else begin
      fail_cnt++;
      $error("Pop or valid set in the cycle after reset");
    end

endmodule

bind bs_burst_sched bank_sched_assert u_assert (
  .clk(clk), .rst_n(rst_n), .pop_o(pop_o), .empty_i(empty_i), .valid_o(valid_o)
);

// ==== verif/bank_sched_tb.sv ====
//**********************************************************
// Testbench for the bank scheduler with a table of load rounds
// Each entry loads the FIFOs, holds ready low and then drains
//**********************************************************
`timescale 1ns/1ns

module bank_sched_tb;
  import bs_pkg::*;

  localparam int N_TESTS    = 6;
  localparam int TIMEOUT_NS = N_TESTS * 64 * 8;   // 64 cycles of 8 ns per entry

  typedef struct {
    string                  name;
    logic [RD_FIFO_NUM-1:0] rd_push;   // Read FIFOs loaded each round
    logic [WR_FIFO_NUM-1:0] wr_push;   // Write FIFOs loaded each round
    int                     rounds;
    bit                     spread;    // Own burst per FIFO and round
    logic [BURST_W-1:0]     base;      // Burst of FIFO 0 in round 0
    int                     hold;      // Cycles of ready low once loaded
    bus_mode_e              exp_mode;  // Bus mode after loading
  } entry_t;

  logic                   clk;
  logic                   rst_n;
  logic [RD_FIFO_NUM-1:0] rd_push;
  rd_req_t                rd_req;
  logic [WR_FIFO_NUM-1:0] wr_push;
  wr_req_t                wr_req;
  logic                   ready;
  logic [RD_FIFO_NUM-1:0] rd_full;
  logic [WR_FIFO_NUM-1:0] wr_full;
  logic                   issue_valid;
  issue_t                 issue;
  bus_mode_e              mode;

  entry_t             tests [N_TESTS];
  issue_t             model_q [FIFO_NUM][$];  // Expected issue words in push order
  integer             seed = 19671;
  int                 errors = 0;
  int                 rd_rr = 0;              // Expected round-robin pointers
  int                 wr_rr = 0;
  bus_mode_e          exp_mode = MODE_READ;   // Modeled bus mode of the current cycle
  bit                 in_burst = 1'b0;
  bit                 cur_wr;
  logic [BURST_W-1:0] cur_burst;              // Burst opened by the last leader
  bit                 last_lead_wr = 1'b0;
  string              cur_name = "reset";

  bank_sched_top u_dut (
    .clk(clk), .rst_n(rst_n), .rd_push_i(rd_push), .rd_req_i(rd_req),
    .wr_push_i(wr_push), .wr_req_i(wr_req), .ready_i(ready),
    .rd_full_o(rd_full), .wr_full_o(wr_full), .issue_valid_o(issue_valid),
    .issue_o(issue), .mode_o(mode)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int q_total(input int lo, input int hi);
    int n = 0;
    for (int i = lo; i < hi; i++) n += model_q[i].size();
    return n;
  endfunction

  // Leader takes the pointer FIFO if loaded and otherwise the lowest loaded one
  function automatic int next_fifo(input bit wr, input bit lead, input logic [BURST_W-1:0] b);
    int lo = wr ? RD_FIFO_NUM : 0;
    int hi = wr ? FIFO_NUM : RD_FIFO_NUM;
    int rr = wr ? RD_FIFO_NUM + wr_rr : rd_rr;
    if (lead && model_q[rr].size() != 0) return rr;
    for (int i = lo; i < hi; i++) begin
      if (model_q[i].size() != 0 && (lead || model_q[i][0].burst == b)) return i;
    end
    return -1;   // Nothing left to pop
  endfunction

  function automatic logic [BURST_W-1:0] burst_of(input entry_t e, input int f, input int r);
    return e.spread ? e.base + BURST_W'(f + 8 * r) : e.base;
  endfunction

  task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      errors++;
      $display("Error %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
    end
  endtask

  task automatic report_if(input bit ok, input string msg);
    assert (ok) else begin
      errors++;
      $display("Check failed in %s: %s", cur_name, msg);
    end
  endtask

  // One slot per cycle where a read and a write push may share a slot
  task automatic load_entry(input entry_t e);
    logic [COL_W-1:0]  col;
    logic [DATA_W-1:0] data;
    logic [TAG_W-1:0]  tag;
    for (int r = 0; r < e.rounds; r++) begin
      for (int k = 0; k < RD_FIFO_NUM; k++) begin
        col  = COL_W'($random(seed));
        data = $random(seed);
        tag  = TAG_W'($random(seed));
        @(posedge clk);
        rd_push <= e.rd_push[k] ? RD_FIFO_NUM'(1 << k) : '0;
        rd_req  <= rd_req_t'{burst: burst_of(e, k, r), col: col, tag: tag};
        wr_push <= (k < WR_FIFO_NUM && e.wr_push[k]) ? WR_FIFO_NUM'(1 << k) : '0;
        wr_req  <= wr_req_t'{burst: burst_of(e, RD_FIFO_NUM + k, r), col: ~col, data: data};
      end
    end
    @(posedge clk);
    rd_push <= '0;
    wr_push <= '0;
  endtask

  //**********************************************************
  // Scoreboard sampled mid-cycle where outputs are settled
  //**********************************************************
  always @(negedge clk) begin
    int                f;
    int                lead;
    int                wr_pend;
    int                rd_pend;
    bit                exp_wr;
    bit [FIFO_NUM-1:0] was_full;
    if (!rst_n) begin
      exp_mode = MODE_READ;                   // Read first out of reset
    end else begin
      wr_pend = q_total(RD_FIFO_NUM, FIFO_NUM);
      rd_pend = q_total(0, RD_FIFO_NUM);
      exp_wr  = (exp_mode == MODE_WRITE);
      report_value("bus mode", exp_mode, mode);
      for (int i = 0; i < FIFO_NUM; i++) begin
        was_full[i] = (model_q[i].size() >= FIFO_DEPTH);
      end
      report_value("read full", was_full[RD_FIFO_NUM-1:0], rd_full);
      report_value("write full", was_full[FIFO_NUM-1:RD_FIFO_NUM], wr_full);
      if (issue_valid && ready) begin
        f = int'(issue.idx);
        if (!in_burst) begin                  // Burst leader follows mode and RR
          lead = next_fifo(exp_wr, 1'b1, '0);
          report_value("lead FIFO", lead, f);
          if (exp_wr) begin
            wr_rr = (wr_rr + 1) % WR_FIFO_NUM;
            report_if(wr_pend > WR_LO_MARK || rd_pend == 0,
                      "write issued while reads wait at the low watermark");
          end else begin
            rd_rr = (rd_rr + 1) % RD_FIFO_NUM;
            report_if(wr_pend < WR_HI_MARK, "read issued with writes at the high watermark");
            report_if(!last_lead_wr || wr_pend <= WR_LO_MARK,
                      "write mode left above the low watermark");
          end
          in_burst     = 1'b1;
          cur_wr       = exp_wr;
          cur_burst    = (lead >= 0) ? model_q[lead][0].burst : '0;
          last_lead_wr = exp_wr;
        end else begin
          report_value("burst member", next_fifo(cur_wr, 1'b0, cur_burst), f);
        end
        if (f < FIFO_NUM && model_q[f].size() != 0) begin
          report_value("issue word", model_q[f][0], issue);
          void'(model_q[f].pop_front());
        end else begin
          report_if(1'b0, "issue from a FIFO that holds no request");
        end
      end else if (in_burst) begin            // No matching head may remain once valid falls
        report_value("head left at burst end", -1, next_fifo(cur_wr, 1'b0, cur_burst));
        in_burst = 1'b0;
      end
      for (int i = 0; i < RD_FIFO_NUM; i++) begin
        if (rd_push[i] && !was_full[i]) begin  // Push to a full FIFO is dropped
          model_q[i].push_back(issue_t'{wr: 1'b0, idx: IDX_W'(i), burst: rd_req.burst,
                                        col: rd_req.col, data: '0, tag: rd_req.tag});
        end
      end
      for (int i = 0; i < WR_FIFO_NUM; i++) begin
        if (wr_push[i] && !was_full[RD_FIFO_NUM+i]) begin
          model_q[RD_FIFO_NUM+i].push_back(issue_t'{wr: 1'b1, idx: IDX_W'(RD_FIFO_NUM + i),
                                                    burst: wr_req.burst, col: wr_req.col,
                                                    data: wr_req.data, tag: '0});
        end
      end
      // Watermark hysteresis on this cycle's pending counts sets next cycle's mode
      if (exp_mode == MODE_READ) begin
        if (wr_pend >= WR_HI_MARK || (rd_pend == 0 && wr_pend != 0)) exp_mode = MODE_WRITE;
      end else if (wr_pend == 0 || (wr_pend <= WR_LO_MARK && rd_pend != 0)) begin
        exp_mode = MODE_READ;
      end
    end
  end

  //**********************************************************
  // Stimulus table and run
  //**********************************************************
  initial begin
    int sva_fails;
    tests[0] = '{"read_group",  4'b1111, 3'b000, 1, 1'b0, 16'h0100, 3, MODE_READ};
    tests[1] = '{"read_first",  4'b0101, 3'b011, 1, 1'b1, 16'h0200, 2, MODE_READ};
    tests[2] = '{"watermark",   4'b0011, 3'b111, 2, 1'b1, 16'h0300, 4, MODE_WRITE};
    tests[3] = '{"round_robin", 4'b1111, 3'b000, 2, 1'b1, 16'h0400, 0, MODE_READ};
    tests[4] = '{"write_drain", 4'b0000, 3'b101, 1, 1'b0, 16'h0500, 2, MODE_WRITE};
    tests[5] = '{"mixed_group", 4'b1011, 3'b010, 1, 1'b0, 16'h0600, 1, MODE_READ};
    rst_n   = 1'b0;
    rd_push = '0;
    rd_req  = '0;
    wr_push = '0;
    wr_req  = '0;
    ready   = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < N_TESTS; t++) begin
      cur_name     = tests[t].name;
      last_lead_wr = 1'b0;
      load_entry(tests[t]);
      repeat (4) @(posedge clk);              // Mode register and FSM settle
      @(negedge clk);
      report_value("mode", tests[t].exp_mode, mode);
      repeat (tests[t].hold) begin            // Offer held without a pop under back-pressure
        @(negedge clk);
        report_if(issue_valid === 1'b1, "issue valid dropped while ready was low");
        report_value("issue under back-pressure", '0, issue);
      end
      @(posedge clk);
      ready <= 1'b1;
      @(negedge clk);
      while (issue_valid || q_total(0, FIFO_NUM) != 0) @(negedge clk);
      repeat (3) @(negedge clk);              // Lets the FSM fall back to IDLE
      @(posedge clk);
      ready <= 1'b0;
    end
    sva_fails = u_dut.u_sched.u_assert.fail_cnt;
    errors    = errors + sva_fails;
    $display("Errors: %0d total, %0d from bound assertions", errors, sva_fails);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the scheduler did not drain its FIFOs in time");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== list.f ====
source/bs_pkg.sv
source/bs_req_fifo.sv
source/bs_mode_ctrl.sv
source/bs_burst_sched.sv
source/bank_sched_top.sv
verif/bank_sched_assert.sv
verif/bank_sched_tb.sv

// ==== Bender.yml ====
package:
  name: bank_sched

sources:
  - files:
      - source/bs_pkg.sv
      - source/bs_req_fifo.sv
      - source/bs_mode_ctrl.sv
      - source/bs_burst_sched.sv
      - source/bank_sched_top.sv
  - target: test
    files:
      - verif/bank_sched_assert.sv
      - verif/bank_sched_tb.sv
